//--- Makefile
# Verilator build and run for the ADS868x controller testbench

VERILATOR ?= verilator
TOP       ?= ads868x_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f
VFLAGS    ?= --binary --timing --assert

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^PASS: all tests$$"

clean:
	rm -rf $(OBJ_DIR)

//--- common/ads868x_pkg.sv
// Shared types for the ADS868x controller. This holds the bus word types, the
// register map and the structs that pass between the register file, the
// sequencer and the SPI master.

`include "ads868x_settings.svh"

package ads868x_pkg;

    typedef logic [`ADS_ADDR_W-1:0] up_addr_t;
    typedef logic [`ADS_DATA_W-1:0] up_data_t;
    typedef logic [1:0]             byte_cnt_t;  // frame bytes minus one
    typedef logic [2:0]             mux_sel_t;
    typedef logic [3:0]             mux_en_t;

    // register map
    localparam up_addr_t REG_SOFT_RESET = 'd0;
    localparam up_addr_t REG_POWER_DOWN = 'd1;
    localparam up_addr_t REG_AUTO_MODE  = 'd2;
    localparam up_addr_t REG_MUX_SEL    = 'd3;
    localparam up_addr_t REG_MUX_EN     = 'd4;
    localparam up_addr_t REG_BYTE_CNT   = 'd5;
    localparam up_addr_t REG_TX_DATA    = 'd6;
    localparam up_addr_t REG_RX_DATA    = 'd7;
    localparam up_addr_t REG_RX_VALID   = 'd8;
    localparam up_addr_t REG_VERSION    = 'd9;

    localparam up_data_t  RD_UNMAPPED  = 32'hDEADBEEF;
    localparam byte_cnt_t BYTE_CNT_RST = 2'd3;

    typedef struct packed {
        logic      soft_reset;
        logic      power_down;
        logic      auto_mode;
        byte_cnt_t byte_cnt;
    } ads_ctrl_t;

    typedef struct packed {
        byte_cnt_t byte_cnt;
        up_data_t  word;
    } spi_cmd_t;

    typedef struct packed {
        up_data_t data;
        logic     valid;
    } spi_rsp_t;

    typedef enum logic [1:0] {SEQ_IDLE, SEQ_FRAME, SEQ_GAP} seq_state_t;
    typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_DONE} spi_state_t;

endpackage

//--- common/ads868x_settings.svh
// Build-time settings for the ADS868x SPI ADC controller.
// Include this wherever a width, a timing constant or the version word is
// needed. The types built on these values live in the package.

`ifndef ADS868X_SETTINGS_SVH
`define ADS868X_SETTINGS_SVH

// ---------------------------------------------------------------------------
// host bus
// ---------------------------------------------------------------------------
`define ADS_ADDR_W 10
`define ADS_DATA_W 32

// ---------------------------------------------------------------------------
// SPI timing, in system clock cycles
// ---------------------------------------------------------------------------

// one serial clock half period
`define ADS_SCLK_DIV 2

// chip select high time between auto-mode frames
`define ADS_CONV_GAP 20

// read back at register 9
`define ADS_VERSION 32'h0001_0300

`endif

//--- regs/ads868x_regs.sv
// Host register file for the ADS868x controller.
// Single-cycle read and write strobes are acknowledged one cycle later.
// Control fields go out to the sequencer and the mux pins, and the SPI
// response comes back in as read-only status.

`timescale 1ns/1ps
`include "ads868x_settings.svh"

module ads868x_regs (
    input  logic                   clk,
    input  logic                   rst,
    // write channel
    input  ads868x_pkg::up_addr_t  up_wr_addr,
    input  logic                   up_wr_req,
    input  logic [3:0]             up_wr_be,
    input  ads868x_pkg::up_data_t  up_wr_data,
    output logic                   up_wr_ack,
    // read channel
    input  ads868x_pkg::up_addr_t  up_rd_addr,
    input  logic                   up_rd_req,
    output ads868x_pkg::up_data_t  up_rd_data,
    output logic                   up_rd_ack,
    // core side
    output ads868x_pkg::ads_ctrl_t ctrl,
    output ads868x_pkg::mux_sel_t  mux_sel,
    output ads868x_pkg::mux_en_t   mux_en,
    output ads868x_pkg::up_data_t  tx_word,
    output logic                   tx_strobe,
    input  ads868x_pkg::spi_rsp_t  rsp
);

    import ads868x_pkg::*;

    logic wr_lo;
    logic wr_tx;

    // narrow fields only take a write when byte 0 is enabled
    assign wr_lo = up_wr_req & up_wr_be[0];
    assign wr_tx = up_wr_req && (up_wr_addr == REG_TX_DATA);

    // ------------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl    <= '{soft_reset: 1'b0, power_down: 1'b0, auto_mode: 1'b0,
                         byte_cnt: BYTE_CNT_RST};
            mux_sel <= '0;
            mux_en  <= '0;
        end else if (wr_lo) begin
            case (up_wr_addr)
                REG_SOFT_RESET: ctrl.soft_reset <= up_wr_data[0];
                REG_POWER_DOWN: ctrl.power_down <= up_wr_data[0];
                REG_AUTO_MODE:  ctrl.auto_mode  <= up_wr_data[0];
                REG_MUX_SEL:    mux_sel         <= up_wr_data[2:0];
                REG_MUX_EN:     mux_en          <= up_wr_data[3:0];
                REG_BYTE_CNT:   ctrl.byte_cnt   <= up_wr_data[1:0];
                default: ;
            endcase
        end
    end

    // transmit word, merged per enabled byte
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_word <= '0;
        end else if (wr_tx) begin
            for (int i = 0; i < 4; i++) begin
                if (up_wr_be[i]) begin
                    tx_word[i*8 +: 8] <= up_wr_data[i*8 +: 8];
                end
            end
        end
    end

    // acks and the frame request both land one cycle after the strobe.
    // tx_strobe fires on any write to the tx register, even with no bytes enabled
    always_ff @(posedge clk) begin
        if (rst) begin
            up_wr_ack <= 1'b0;
            up_rd_ack <= 1'b0;
            tx_strobe <= 1'b0;
        end else begin
            up_wr_ack <= up_wr_req;
            up_rd_ack <= up_rd_req;
            tx_strobe <= wr_tx;
        end
    end

    // ------------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------------

    // registered so data lines up with up_rd_ack
    always_ff @(posedge clk) begin
        if (up_rd_req) begin
            case (up_rd_addr)
                REG_SOFT_RESET: up_rd_data <= up_data_t'(ctrl.soft_reset);
                REG_POWER_DOWN: up_rd_data <= up_data_t'(ctrl.power_down);
                REG_AUTO_MODE:  up_rd_data <= up_data_t'(ctrl.auto_mode);
                REG_MUX_SEL:    up_rd_data <= up_data_t'(mux_sel);
                REG_MUX_EN:     up_rd_data <= up_data_t'(mux_en);
                REG_BYTE_CNT:   up_rd_data <= up_data_t'(ctrl.byte_cnt);
                REG_TX_DATA:    up_rd_data <= tx_word;
                REG_RX_DATA:    up_rd_data <= rsp.data;
                REG_RX_VALID:   up_rd_data <= up_data_t'(rsp.valid);
                REG_VERSION:    up_rd_data <= `ADS_VERSION;
                default:        up_rd_data <= RD_UNMAPPED;
            endcase
        end
    end

endmodule

//--- spi/ads868x_spi_master.sv
// SPI mode-0 master for the ADS868x. It runs frames of 1 to 4 bytes, MSB
// first, from the top bytes of the command word. One setup cycle follows the
// chip select fall, and the received word is captured right-aligned.

`timescale 1ns/1ps
`include "ads868x_settings.svh"

module ads868x_spi_master (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    input  ads868x_pkg::spi_cmd_t cmd,
    input  logic                  spi_abort,
    output logic                  busy,
    output ads868x_pkg::spi_rsp_t rsp,
    output logic                  cs_n,
    output logic                  sclk,
    output logic                  mosi,
    input  logic                  miso
);

    import ads868x_pkg::*;

    localparam int DIV_W = (`ADS_SCLK_DIV > 1) ? $clog2(`ADS_SCLK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`ADS_SCLK_DIV - 1);

    spi_state_t       state;
    logic             setup;
    logic [DIV_W-1:0] div_cnt;
    logic [4:0]       bit_cnt;
    logic [4:0]       bit_last;
    up_data_t         tx_sr;
    up_data_t         rx_sr;
    logic             rx_valid;
    logic             load;
    logic             half_done;
    logic             rise;
    logic             fall;

    // last bit index is bytes*8-1
    assign bit_last  = {cmd.byte_cnt, 3'b111};
    assign load      = (state == SPI_IDLE) && start && !spi_abort;
    assign half_done = (state == SPI_SHIFT) && !setup && (div_cnt == DIV_LAST);
    assign rise      = half_done && !sclk;
    assign fall      = half_done && sclk;

    assign mosi = tx_sr[`ADS_DATA_W-1];
    assign rsp  = '{data: rx_sr, valid: rx_valid};

    // ------------------------------------------------------------------------
    // frame control and serial clock
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst || spi_abort) begin
            state    <= SPI_IDLE;
            busy     <= 1'b0;
            cs_n     <= 1'b1;
            sclk     <= 1'b0;
            setup    <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            case (state)
                SPI_IDLE: begin
                    if (start) begin
                        state    <= SPI_SHIFT;
                        busy     <= 1'b1;
                        cs_n     <= 1'b0;
                        setup    <= 1'b1;
                        div_cnt  <= '0;
                        bit_cnt  <= '0;
                        rx_valid <= 1'b0;
                    end
                end
                SPI_SHIFT: begin
                    setup <= 1'b0;
                    if (half_done) begin
                        div_cnt <= '0;
                        sclk    <= ~sclk;
                    end else if (!setup) begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                    if (fall) begin
                        if (bit_cnt == bit_last) begin
                            // sclk returns low on this same edge
                            cs_n     <= 1'b1;
                            rx_valid <= 1'b1;
                            state    <= SPI_DONE;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                SPI_DONE: begin
                    busy  <= 1'b0;
                    state <= SPI_IDLE;
                end
                default: state <= SPI_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // shift registers
    // ------------------------------------------------------------------------

    // sample on the rising edge, next mosi bit on the falling edge
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_sr <= '0;
            rx_sr <= '0;
        end else if (load) begin
            tx_sr <= cmd.word;
            rx_sr <= '0;
        end else if (rise) begin
            rx_sr <= {rx_sr[`ADS_DATA_W-2:0], miso};
        end else if (fall) begin
            tx_sr <= {tx_sr[`ADS_DATA_W-2:0], 1'b0};
        end
    end

endmodule

//--- src/ads868x_conv_seq.sv
// Conversion sequencer. It decides when the SPI master runs a frame: once
// per transmit-data write in manual mode, or back to back with a fixed
// conversion gap in auto mode. Power down and soft reset hold off new frames.

`timescale 1ns/1ps
`include "ads868x_settings.svh"

module ads868x_conv_seq (
    input  logic                   clk,
    input  logic                   rst,
    input  ads868x_pkg::ads_ctrl_t ctrl,
    input  logic                   tx_strobe,
    input  ads868x_pkg::up_data_t  tx_word,
    input  logic                   busy,
    output logic                   start,
    output ads868x_pkg::spi_cmd_t  cmd,
    output logic                   spi_abort
);

    import ads868x_pkg::*;

    localparam int GAP_W = $clog2(`ADS_CONV_GAP + 1);

    seq_state_t       state;
    logic [GAP_W-1:0] gap_cnt;
    logic             issue_ok;
    spi_cmd_t         cmd_live;
    spi_cmd_t         cmd_q;

    assign issue_ok = !ctrl.power_down && !ctrl.soft_reset && !busy;

    // start is decoded from the current control fields, so a power down
    // that is already set always suppresses it
    always_comb begin
        case (state)
            SEQ_IDLE: start = issue_ok && (ctrl.auto_mode || tx_strobe);
            SEQ_GAP:  start = issue_ok && ctrl.auto_mode && (gap_cnt == '0);
            default:  start = 1'b0;
        endcase
    end

    // the master sees the live command in the start cycle, then the held copy
    assign cmd_live = '{byte_cnt: ctrl.byte_cnt, word: tx_word};
    assign cmd      = start ? cmd_live : cmd_q;

    always_ff @(posedge clk) begin
        if (start) begin
            cmd_q <= cmd_live;
        end
    end

    assign spi_abort = ctrl.soft_reset;

    always_ff @(posedge clk) begin
        if (rst || ctrl.soft_reset) begin
            state   <= SEQ_IDLE;
            gap_cnt <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (start) begin
                        state <= SEQ_FRAME;
                    end
                end
                SEQ_FRAME: begin
                    // busy is already high in the first FRAME cycle
                    if (!busy) begin
                        if (ctrl.auto_mode && !ctrl.power_down) begin
                            state   <= SEQ_GAP;
                            gap_cnt <= GAP_W'(`ADS_CONV_GAP - 1);
                        end else begin
                            state <= SEQ_IDLE;
                        end
                    end
                end
                SEQ_GAP: begin
                    if (start) begin
                        state <= SEQ_FRAME;
                    end else if (gap_cnt != '0) begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end else begin
                        state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

//--- src/ads868x_top.sv
// Top level of the ADS868x controller. It connects the host register bus to
// the register file, which drives the conversion sequencer and the SPI
// master. The mux select and enable fields go straight out to the pins.

`timescale 1ns/1ps

module ads868x_top (
    input  logic                  clk,
    input  logic                  rst,
    // host register bus
    input  ads868x_pkg::up_addr_t up_wr_addr,
    input  logic                  up_wr_req,
    input  logic [3:0]            up_wr_be,
    input  ads868x_pkg::up_data_t up_wr_data,
    output logic                  up_wr_ack,
    input  ads868x_pkg::up_addr_t up_rd_addr,
    input  logic                  up_rd_req,
    output ads868x_pkg::up_data_t up_rd_data,
    output logic                  up_rd_ack,
    // ADC serial port
    output logic                  cs_n,
    output logic                  sclk,
    output logic                  mosi,
    input  logic                  miso,
    // external analog mux
    output ads868x_pkg::mux_sel_t mux_sel,
    output ads868x_pkg::mux_en_t  mux_en
);

    import ads868x_pkg::*;

    ads_ctrl_t ctrl;
    up_data_t  tx_word;
    logic      tx_strobe;
    spi_rsp_t  rsp;
    logic      start;
    spi_cmd_t  cmd;
    logic      spi_abort;
    logic      busy;

    ads868x_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .up_wr_addr (up_wr_addr),
        .up_wr_req  (up_wr_req),
        .up_wr_be   (up_wr_be),
        .up_wr_data (up_wr_data),
        .up_wr_ack  (up_wr_ack),
        .up_rd_addr (up_rd_addr),
        .up_rd_req  (up_rd_req),
        .up_rd_data (up_rd_data),
        .up_rd_ack  (up_rd_ack),
        .ctrl       (ctrl),
        .mux_sel    (mux_sel),
        .mux_en     (mux_en),
        .tx_word    (tx_word),
        .tx_strobe  (tx_strobe),
        .rsp        (rsp)
    );

    ads868x_conv_seq u_seq (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .tx_strobe (tx_strobe),
        .tx_word   (tx_word),
        .busy      (busy),
        .start     (start),
        .cmd       (cmd),
        .spi_abort (spi_abort)
    );

    ads868x_spi_master u_spi (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .cmd       (cmd),
        .spi_abort (spi_abort),
        .busy      (busy),
        .rsp       (rsp),
        .cs_n      (cs_n),
        .sclk      (sclk),
        .mosi      (mosi),
        .miso      (miso)
    );

endmodule

//--- tb.f
+incdir+common
common/ads868x_pkg.sv
regs/ads868x_regs.sv
src/ads868x_conv_seq.sv
spi/ads868x_spi_master.sv
src/ads868x_top.sv
tb/ads868x_asserts.sv
tb/ads868x_tb.sv

//--- tb/ads868x_asserts.sv
// Concurrent assertions for the ADS868x top level, attached with bind.
// Covers acknowledge timing, the idle serial clock and power down.

`timescale 1ns/1ps

module ads868x_asserts (
    input logic clk,
    input logic rst,
    input logic wr_req,
    input logic wr_ack,
    input logic rd_req,
    input logic rd_ack,
    input logic cs_n,
    input logic sclk,
    input logic power_down
);

    // each ack is the request delayed by exactly one cycle
    assert property (@(posedge clk) disable iff (rst) wr_ack == $past(wr_req))
        else $error("wr_ack does not follow wr_req by one cycle");
    assert property (@(posedge clk) disable iff (rst) rd_ack == $past(rd_req))
        else $error("rd_ack does not follow rd_req by one cycle");

    assert property (@(posedge clk) disable iff (rst) cs_n |-> !sclk)
        else $error("sclk high while cs_n is high");

    // a frame may only begin while power down is clear
    assert property (@(posedge clk) disable iff (rst) $fell(cs_n) |-> !$past(power_down))
        else $error("frame start issued during power down");

endmodule

bind ads868x_top ads868x_asserts u_asserts (
    .clk        (clk),
    .rst        (rst),
    .wr_req     (up_wr_req),
    .wr_ack     (up_wr_ack),
    .rd_req     (up_rd_req),
    .rd_ack     (up_rd_ack),
    .cs_n       (cs_n),
    .sclk       (sclk),
    .power_down (ctrl.power_down)
);

//--- tb/ads868x_tb.sv
// Trace-driven testbench for the ADS868x controller.
// Bus operations, ADC response words and expected values come from
// tb/ads868x_trace.txt, read from the project root. An ADC model answers on miso.

`timescale 1ns/1ps
`include "ads868x_settings.svh"

module ads868x_tb;

    import ads868x_pkg::*;

    localparam int FRAME_CYCLES = 4 * 8 * 2 * `ADS_SCLK_DIV + 1 + `ADS_CONV_GAP;

    logic      clk;
    logic      rst;
    up_addr_t  up_wr_addr;
    logic      up_wr_req;
    logic [3:0] up_wr_be;
    up_data_t  up_wr_data;
    logic      up_wr_ack;
    up_addr_t  up_rd_addr;
    logic      up_rd_req;
    up_data_t  up_rd_data;
    logic      up_rd_ack;
    logic      cs_n;
    logic      sclk;
    logic      mosi;
    logic      miso;
    mux_sel_t  mux_sel;
    mux_en_t   mux_en;

    // ADC model state
    logic [31:0] adc_word;
    logic [31:0] mosi_bits;
    int          mosi_cnt;
    int          adc_idx;
    int          frames;
    logic        cs_q;
    logic        sclk_q;

    int errors;
    int n_lines;

    ads868x_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // ADC serial model, mode 0
    // ------------------------------------------------------------------------

    // next miso bit after each falling sclk, mosi captured on rising sclk
    always @(posedge clk) begin
        cs_q   <= cs_n;
        sclk_q <= sclk;
        if (!cs_n && cs_q) begin
            miso      <= adc_word[31];
            adc_idx   <= 30;
            mosi_bits <= '0;
            mosi_cnt  <= 0;
        end else if (!cs_n && sclk_q && !sclk && adc_idx >= 0) begin
            miso    <= adc_word[adc_idx];
            adc_idx <= adc_idx - 1;
        end
        if (!cs_n && !sclk_q && sclk) begin
            mosi_bits <= {mosi_bits[30:0], mosi};
            mosi_cnt  <= mosi_cnt + 1;
        end
        if (cs_n && !cs_q) begin
            frames <= frames + 1;
        end
    end

    // ------------------------------------------------------------------------
    // checks and bus tasks
    // ------------------------------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [3:0] be,
                             input logic [31:0] data);
        @(posedge clk);
        up_wr_addr <= up_addr_t'(addr);
        up_wr_be   <= be;
        up_wr_data <= data;
        up_wr_req  <= 1'b1;
        @(posedge clk);
        up_wr_req <= 1'b0;
        @(negedge clk);
        if (up_wr_ack !== 1'b1) begin
            errors++;
            $display("write to address %h was not acknowledged one cycle later", addr);
        end
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        up_rd_addr <= up_addr_t'(addr);
        up_rd_req  <= 1'b1;
        @(posedge clk);
        up_rd_req <= 1'b0;
        @(negedge clk);
        data = up_rd_data;
        if (up_rd_ack !== 1'b1) begin
            errors++;
            $display("read of address %h was not acknowledged one cycle later", addr);
        end
    endtask

    task automatic poll_valid(input logic [31:0] exp);
        logic [31:0] data;
        int          tries;
        tries = 0;
        data  = ~exp;
        while (data !== exp && tries < FRAME_CYCLES) begin
            bus_read(32'd8, data);
            tries++;
        end
        if (data !== exp) begin
            errors++;
            $display("received valid never reached %h", exp);
        end
    endtask

    // waits for count frames and checks the command bits of each
    task automatic check_frames(input int count, input logic [31:0] exp);
        int n0;
        int waited;
        for (int i = 0; i < count; i++) begin
            n0     = frames;
            waited = 0;
            while (frames == n0 && waited < 2 * FRAME_CYCLES) begin
                @(negedge clk);
                waited++;
            end
            if (frames == n0) begin
                errors++;
                $display("auto frame %0d did not appear", i);
            end else begin
                check_value("mosi", mosi_bits, exp);
            end
        end
    endtask

    task automatic wait_cs(input logic level);
        int waited;
        waited = 0;
        while (cs_n !== level && waited < 2 * FRAME_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (cs_n !== level) begin
            errors++;
            $display("chip select did not go to %b in time", level);
        end
    endtask

    task automatic check_quiet(input int cycles);
        wait_cs(1'b1);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (cs_n !== 1'b1) begin
                errors++;
                $display("a frame started while power down was set");
                break;
            end
        end
    endtask

    // soft reset takes chip select high on the next clock
    task automatic check_abort();
        @(negedge clk);
        if (cs_n !== 1'b1) begin
            errors++;
            $display("soft reset did not end the frame in flight");
        end
    endtask

    // ------------------------------------------------------------------------
    // trace replay
    // ------------------------------------------------------------------------

    initial begin
        int          fd;
        string       line;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] be;
        logic [31:0] val;
        logic [31:0] data;
        up_wr_addr = '0;
        up_wr_req  = 1'b0;
        up_wr_be   = '0;
        up_wr_data = '0;
        up_rd_addr = '0;
        up_rd_req  = 1'b0;
        miso       = 1'b0;
        adc_word   = '0;
        mosi_bits  = '0;
        mosi_cnt   = 0;
        adc_idx    = -1;
        frames     = 0;
        cs_q       = 1'b1;
        sclk_q     = 1'b0;
        errors     = 0;
        n_lines    = 0;
        rst        = 1'b1;
        fd = $fopen("tb/ads868x_trace.txt", "r");
        if (fd == 0) begin
            $display("trace file tb/ads868x_trace.txt could not be opened");
            $display("FAIL: see errors above");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) != 0) begin
                    n_lines++;
                end
            end
            $fclose(fd);
            repeat (4) @(posedge clk);
            rst <= 1'b0;
            fd = $fopen("tb/ads868x_trace.txt", "r");
            while ($fscanf(fd, " %c", op) == 1) begin
                if (op == "#") begin
                    void'($fgets(line, fd));
                end else begin
                    void'($fscanf(fd, "%h %h %h", addr, be, val));
                    case (op)
                        "W": begin
                            bus_write(addr, be[3:0], val);
                            if (addr == 32'd0 && be[0] && val[0]) begin
                                check_abort();
                            end
                        end
                        "R": begin
                            bus_read(addr, data);
                            check_value("up_rd_data", data, val);
                        end
                        "A": adc_word = val;
                        "P": poll_valid(val);
                        "M": begin
                            check_value("mux_sel", 32'(mux_sel), 32'(val[6:4]));
                            check_value("mux_en", 32'(mux_en), 32'(val[3:0]));
                        end
                        "F": begin
                            check_value("mosi bit count", 32'(mosi_cnt), addr);
                            check_value("mosi", mosi_bits, val);
                        end
                        "C": check_frames(int'(addr), val);
                        "L": wait_cs(1'b0);
                        "Q": check_quiet(int'(addr));
                        default: begin
                            errors++;
                            $display("unknown trace operation %c", op);
                        end
                    endcase
                end
            end
            $fclose(fd);
            $display("errors: %0d", errors);
            if (errors == 0) begin
                $display("PASS: all tests");
            end else begin
                $display("FAIL: see errors above");
            end
            $finish;
        end
    end

    // watchdog scaled from the trace length
    initial begin
        @(negedge rst);
        #(n_lines * FRAME_CYCLES * 4 * 10);
        $display("timeout: the trace did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- tb/ads868x_trace.txt
# columns: op addr be value, all hex. W write, R read+compare, A adc word, P poll addr 8,
# M mux {sel[6:4],en[3:0]}, F mosi (addr=bits), C auto frames (addr=count), L cs low, Q quiet cycles
R 000 f 00000000
R 002 f 00000000
R 005 f 00000003
R 007 f 00000000
R 008 f 00000000
R 009 f 00010300
R 0c8 f deadbeef
W 006 f 11223344
W 006 2 aabbccdd
R 006 f 1122cc44
P 008 f 00000001
W 003 f 00000005
W 003 e 00000002
R 003 f 00000005
W 004 f 0000000a
M 000 0 0000005a
A 000 0 a5c31234
W 005 f 00000001
W 006 f cafe0055
P 008 f 00000001
R 007 f 0000a5c3
F 010 0 0000cafe
A 000 0 12345678
W 005 f 00000002
W 006 f 8899aabb
P 008 f 00000001
R 007 f 00123456
F 018 0 008899aa
A 000 0 0f1e2d3c
W 005 f 00000003
W 006 f 13579bdf
P 008 f 00000001
R 007 f 0f1e2d3c
F 020 0 13579bdf
W 002 f 00000001
C 003 0 13579bdf
W 001 f 00000001
Q 100 0 00000000
W 002 f 00000000
W 001 f 00000000
W 006 f 2468ace0
L 000 0 00000000
W 000 f 00000001
R 008 f 00000000
W 000 f 00000000
W 006 f 2468ace0
P 008 f 00000001
R 007 f 0f1e2d3c
F 020 0 2468ace0
